// ==== lsb.f ====
src/lsb_cfg_pkg.sv
src/lsb_op_pkg.sv
src/byte_counter.sv
src/byte_lane_unit.sv
src/lsb_queue.sv
src/mem_access_fsm.sv
src/lsb_top.sv
verification/lsb_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the load/store buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module lsb_tb \
    -f lsb.f --Mdir "$BUILD_DIR" -o lsb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/lsb_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -qF '** FAIL **' "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi
echo "simulation finished without failure"

// ==== verification/lsb_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsb_tb import lsb_cfg_pkg::*, lsb_op_pkg::*; ();

    localparam int DEPTH        = 16;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int MEM_SIZE     = 2 ** ADDR_W;
    localparam int WAIT_LIMIT   = 200;
    // rough cycle count of all tests
    localparam int TEST_CYCLES  = RESET_CYCLES + 5 * 12 + 2 * 40 + 3 * 40 + DEPTH * 10 + 31 + 120;
    localparam int WATCHDOG_NS  = 4 * TEST_CYCLES * CLK_PERIOD; // four times the test length
    localparam addr_t STORE_BASE = addr_t'(17'h1F000); // loads never reach this region

    logic          clk_in;
    logic          rst_in;
    dispatch_t     dispatch;
    commit_bcast_t commit;
    logic          store_commit;
    logic          clear;
    byte_t         mem_byte;
    mem_req_t      mem_req;
    load_result_t  result;
    logic          full;

    byte_t        mem     [MEM_SIZE]; // what the DUT sees
    byte_t        ref_mem [MEM_SIZE]; // expected contents
    load_result_t got_q [$];
    load_result_t exp_q [$];
    int           n_reads;
    int           n_writes;
    logic [31:0]  lcg_state;
    word_t        tag_base [32];
    mem_op_e      load_ops [5] = '{op_lb, op_lh, op_lw, op_lbu, op_lhu};

    lsb_top #(
        .DEPTH(DEPTH)
    ) u_lsb_top (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .dispatch    (dispatch),
        .commit      (commit),
        .store_commit(store_commit),
        .clear       (clear),
        .mem_byte    (mem_byte),
        .mem_req     (mem_req),
        .result      (result),
        .full        (full)
    );

    always #(CLK_PERIOD / 2) clk_in = ~clk_in;

    // byte memory with read data one cycle after the request
    always @(posedge clk_in) begin
        mem_req_t req;
        byte_t    rd;
        req = mem_req;
        if (req.valid === 1'b1) begin
            if (req.write) begin
                mem[req.addr] = req.wdata;
                n_writes++;
            end else begin
                rd = mem[req.addr];
                n_reads++;
                #1 mem_byte = rd;
            end
        end
    end

    always @(posedge clk_in) begin
        if (rst_in === 1'b0 && result.valid === 1'b1) got_q.push_back(result);
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic word_t rand_base();
        return (lcg_next() & 32'hFFFE_FFFF) | 32'h100; // bit 16 clear keeps loads low
    endfunction

    function automatic word_t rand_imm();
        return word_t'(int'(lcg_next() % 128) - 64);
    endfunction

    function automatic byte_t fill_byte(int a);
        return byte_t'((a * 37) ^ (a >> 8) ^ ((a >> 16) * 8'h95));
    endfunction

    // little-endian gather from the reference memory and extension
    function automatic word_t expect_load(mem_op_e op, addr_t a);
        word_t w;
        int    v;
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = ref_mem[addr_t'(a + addr_t'(i))];
        end
        case (op)
            op_lb:   v = $signed(w[7:0]);
            op_lh:   v = $signed(w[15:0]);
            op_lbu:  v = int'(w[7:0]);
            op_lhu:  v = int'(w[15:0]);
            default: v = int'(w);
        endcase
        return word_t'(v);
    endfunction

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "run stopped");
    endtask

    task automatic check_result(input load_result_t got, input load_result_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("error %0t: load result tag %0d value %h, expected tag %0d value %h",
                                $time, got.tag, got.value, exp.tag, exp.value));
        end
    endtask

    task automatic check_byte(input addr_t a, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("error %0t: memory[%h] is %h, expected %h", $time, a, got, exp));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            fail_stop($sformatf("error %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    // one clock with pulses dropped back to idle
    task automatic next_cycle();
        @(posedge clk_in);
        #1;
        dispatch     = '0;
        commit       = '0;
        store_commit = 1'b0;
        clear        = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic drive_dispatch(input mem_op_e op, input tag_t tag, input word_t imm,
                                  input tag_t rs1_dep, input word_t rs1_val,
                                  input tag_t rs2_dep, input word_t rs2_val);
        dispatch.valid   = 1'b1;
        dispatch.op      = op;
        dispatch.tag     = tag;
        dispatch.imm     = imm;
        dispatch.rs1_dep = rs1_dep;
        dispatch.rs1_val = rs1_val;
        dispatch.rs2_dep = rs2_dep;
        dispatch.rs2_val = rs2_val;
    endtask

    task automatic dispatch_op(input mem_op_e op, input tag_t tag, input word_t imm,
                               input tag_t rs1_dep, input word_t rs1_val,
                               input tag_t rs2_dep, input word_t rs2_val);
        next_cycle();
        if (full) fail_stop("dispatch attempted while the buffer is full");
        drive_dispatch(op, tag, imm, rs1_dep, rs1_val, rs2_dep, rs2_val);
    endtask

    task automatic set_broadcast(input tag_t tag, input word_t value);
        commit.valid = 1'b1;
        commit.tag   = tag;
        commit.value = value;
    endtask

    task automatic broadcast(input tag_t tag, input word_t value);
        next_cycle();
        set_broadcast(tag, value);
    endtask

    task automatic pulse_store_commit();
        next_cycle();
        store_commit = 1'b1;
    endtask

    task automatic pulse_clear();
        next_cycle();
        clear = 1'b1;
    endtask

    task automatic expect_result(input tag_t tag, input word_t value);
        load_result_t r;
        r.valid = 1'b1;
        r.tag   = tag;
        r.value = value;
        exp_q.push_back(r);
    endtask

    task automatic wait_results();
        int waited;
        waited = 0;
        while (got_q.size() < exp_q.size()) begin
            next_cycle();
            waited++;
            if (waited > WAIT_LIMIT) fail_stop("timed out waiting for load results");
        end
        next_cycle(); // room for a stray extra result
        while (exp_q.size() > 0) begin
            check_result(got_q.pop_front(), exp_q.pop_front());
        end
        if (got_q.size() != 0) fail_stop("a load result arrived that was never expected");
    endtask

    task automatic wait_writes(input int target);
        int waited;
        waited = 0;
        while (n_writes < target) begin
            next_cycle();
            waited++;
            if (waited > WAIT_LIMIT) fail_stop("timed out waiting for store writes");
        end
    endtask

    task automatic test_reset();
        rst_in = 1'b1;
        idle_cycles(RESET_CYCLES);
        rst_in = 1'b0;
        check_flag("mem_req.valid after reset", mem_req.valid, 1'b0);
        check_flag("result.valid after reset", result.valid, 1'b0);
        check_flag("full after reset", full, 1'b0);
        next_cycle();
    endtask

    task automatic test_loads();
        word_t rs1;
        word_t imm;
        for (int i = 0; i < 5; i++) begin
            rs1 = rand_base();
            imm = rand_imm();
            dispatch_op(load_ops[i], tag_t'(i + 1), imm, '0, rs1, '0, '0);
            expect_result(tag_t'(i + 1), expect_load(load_ops[i], addr_t'(rs1 + imm)));
        end
        wait_results();
    endtask

    task automatic test_wakeup();
        word_t rs1;
        word_t imm;
        int    reads0;
        rs1    = rand_base();
        imm    = rand_imm();
        reads0 = n_reads;
        dispatch_op(op_lw, 5'd3, imm, 5'd7, 32'hDEAD_BEEF, '0, '0); // stale base
        broadcast(5'd8, rand_base()); // wrong tag
        idle_cycles(10);
        if (n_reads != reads0 || got_q.size() != 0) begin
            fail_stop("load with a pending operand went to memory");
        end
        broadcast(5'd7, rs1);
        expect_result(5'd3, expect_load(op_lw, addr_t'(rs1 + imm)));
        wait_results();
        rs1 = rand_base();
        imm = rand_imm();
        dispatch_op(op_lh, 5'd4, imm, 5'd9, '0, '0, '0);
        set_broadcast(5'd9, rs1); // same cycle as the dispatch
        expect_result(5'd4, expect_load(op_lh, addr_t'(rs1 + imm)));
        wait_results();
    endtask

    task automatic test_stores();
        mem_op_e st_ops [3] = '{op_sb, op_sh, op_sw};
        mem_op_e rd_ops [3] = '{op_lb, op_lhu, op_lw};
        addr_t   a;
        word_t   wval;
        int      nb;
        int      writes0;
        for (int i = 0; i < 3; i++) begin
            a       = STORE_BASE + addr_t'(8 * i);
            wval    = lcg_next();
            nb      = 1 << i;
            writes0 = n_writes;
            dispatch_op(st_ops[i], tag_t'(10 + i), '0, '0, word_t'(a), '0, wval);
            idle_cycles(8);
            if (n_writes != writes0) fail_stop("store wrote memory before store_commit");
            pulse_store_commit();
            wait_writes(writes0 + nb);
            for (int b = 0; b < 4; b++) begin
                if (b < nb) ref_mem[a + addr_t'(b)] = wval[8*b +: 8];
                check_byte(a + addr_t'(b), mem[a + addr_t'(b)], ref_mem[a + addr_t'(b)]);
            end
            dispatch_op(rd_ops[i], tag_t'(20 + i), '0, '0, word_t'(a), '0, '0);
            expect_result(tag_t'(20 + i), expect_load(rd_ops[i], a));
            wait_results();
        end
    endtask

    task automatic test_order_full();
        mem_op_e op;
        tag_t    dep;
        word_t   imm;
        int      n;
        for (int t = 1; t < 32; t++) tag_base[t] = rand_base();
        n = 0;
        next_cycle();
        while (!full) begin
            if (n >= DEPTH) fail_stop("full never went high while filling the queue");
            op  = load_ops[lcg_next() % 5];
            dep = tag_t'(1 + lcg_next() % 31);
            imm = rand_imm();
            drive_dispatch(op, tag_t'(n + 1), imm, dep, '0, '0, '0);
            expect_result(tag_t'(n + 1), expect_load(op, addr_t'(tag_base[dep] + imm)));
            n++;
            next_cycle();
        end
        if (n != DEPTH - 2) fail_stop($sformatf("full rose after %0d dispatches", n));
        if (got_q.size() != 0) fail_stop("a waiting load completed before its broadcast");
        for (int t = 31; t > 0; t--) broadcast(tag_t'(t), tag_base[t]); // reverse order
        wait_results();
        check_flag("full after draining", full, 1'b0);
    endtask

    task automatic test_flush();
        addr_t sa;
        addr_t sb;
        word_t wval;
        int    writes0;
        // load already reading when the clear comes
        dispatch_op(op_lw, 5'd1, '0, '0, rand_base(), '0, '0);
        next_cycle();
        pulse_clear();
        idle_cycles(12);
        if (got_q.size() != 0) fail_stop("aborted load still produced a result");
        sa      = STORE_BASE + addr_t'(17'h40);
        sb      = STORE_BASE + addr_t'(17'h48);
        wval    = lcg_next();
        writes0 = n_writes;
        dispatch_op(op_sw, 5'd2, '0, '0, word_t'(sa), 5'd20, '0); // data still pending
        pulse_store_commit();
        dispatch_op(op_lw, 5'd3, '0, 5'd21, '0, '0, '0);
        dispatch_op(op_sw, 5'd4, '0, '0, word_t'(sb), '0, lcg_next());
        dispatch_op(op_lbu, 5'd5, '0, '0, rand_base(), '0, '0);
        pulse_clear();
        broadcast(5'd21, rand_base());
        broadcast(5'd20, wval);
        wait_writes(writes0 + 4);
        idle_cycles(12);
        if (n_writes != writes0 + 4) fail_stop("flushed store still wrote memory");
        if (got_q.size() != 0) fail_stop("flushed load still produced a result");
        for (int b = 0; b < 4; b++) begin
            ref_mem[sa + addr_t'(b)] = wval[8*b +: 8];
            check_byte(sa + addr_t'(b), mem[sa + addr_t'(b)], ref_mem[sa + addr_t'(b)]);
            check_byte(sb + addr_t'(b), mem[sb + addr_t'(b)], ref_mem[sb + addr_t'(b)]);
        end
        dispatch_op(op_lw, 5'd6, '0, '0, word_t'(sa), '0, '0);
        expect_result(5'd6, expect_load(op_lw, sa));
        wait_results();
    endtask

    initial begin
        #(WATCHDOG_NS);
        fail_stop("watchdog expired, the simulation appears to hang");
    end

    initial begin
        clk_in       = 1'b0;
        rst_in       = 1'b1;
        dispatch     = '0;
        commit       = '0;
        store_commit = 1'b0;
        clear        = 1'b0;
        mem_byte     = '0;
        n_reads      = 0;
        n_writes     = 0;
        lcg_state    = 32'd49;
        for (int a = 0; a < MEM_SIZE; a++) begin
            mem[a]     = fill_byte(a);
            ref_mem[a] = mem[a];
        end
        test_reset();
        test_loads();
        test_wakeup();
        test_stores();
        test_order_full();
        test_flush();
        idle_cycles(4);
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/lsb_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsb_top import lsb_cfg_pkg::*, lsb_op_pkg::*; #(
    parameter int DEPTH = 16
) (
    input  logic          clk_in,
    input  logic          rst_in,
    input  dispatch_t     dispatch,
    input  commit_bcast_t commit,
    input  logic          store_commit,
    input  logic          clear,
    input  byte_t         mem_byte,
    output mem_req_t      mem_req,
    output load_result_t  result,
    output logic          full
);

    lsb_entry_t head;
    logic       head_go;
    logic       abort;
    logic       pop;
    logic       start;
    logic       step;
    logic       capture;
    logic [2:0] remaining;
    logic [1:0] byte_index;
    addr_t      head_addr;
    addr_t      addr;
    byte_t      wdata_byte;
    word_t      result_value;

    assign head_addr = head.rs1_val[ADDR_W-1:0] + head.imm[ADDR_W-1:0]; // low bits of rs1 + imm

    lsb_queue #(
        .DEPTH(DEPTH)
    ) u_lsb_queue (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .dispatch    (dispatch),
        .commit      (commit),
        .store_commit(store_commit),
        .clear       (clear),
        .pop         (pop),
        .head        (head),
        .head_go     (head_go),
        .abort       (abort),
        .full        (full)
    );

    mem_access_fsm u_mem_access_fsm (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .head        (head),
        .head_go     (head_go),
        .abort       (abort),
        .remaining   (remaining),
        .mem_req     (mem_req),
        .wdata_byte  (wdata_byte),
        .addr        (addr),
        .result_value(result_value),
        .start       (start),
        .step        (step),
        .capture     (capture),
        .pop         (pop),
        .result      (result)
    );

    byte_counter u_byte_counter (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .start     (start),
        .step      (step),
        .op        (head.op),
        .base_addr (head_addr),
        .addr      (addr),
        .remaining (remaining),
        .byte_index(byte_index)
    );

    byte_lane_unit u_byte_lane_unit (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .capture     (capture),
        .op          (head.op),
        .store_data  (head.rs2_val),
        .byte_index  (byte_index),
        .mem_byte    (mem_byte),
        .wdata_byte  (wdata_byte),
        .result_value(result_value)
    );

endmodule

`default_nettype wire

// ==== src/mem_access_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_access_fsm import lsb_cfg_pkg::*, lsb_op_pkg::*; (
    input  logic         clk_in,
    input  logic         rst_in,
    input  lsb_entry_t   head,
    input  logic         head_go,
    input  logic         abort,
    input  logic [2:0]   remaining,
    output mem_req_t     mem_req,
    input  byte_t        wdata_byte,
    input  addr_t        addr,
    input  word_t        result_value,
    output logic         start,
    output logic         step,
    output logic         capture,
    output logic         pop,
    output load_result_t result
);

    access_state_e state;
    access_state_e state_next;
    logic          issue;
    logic          finish_load;
    logic          store_op;
    logic          last;

    assign store_op = is_store(head.op);
    assign last     = remaining == 3'd1; // byte being issued is the final one
    assign step     = issue;

    always_comb begin
        state_next  = state;
        issue       = 1'b0;
        start       = 1'b0;
        pop         = 1'b0;
        finish_load = 1'b0;
        case (state)
            st_idle: begin
                if (head_go) begin
                    start = 1'b1;
                    issue = 1'b1;
                    if (last) begin
                        state_next = store_op ? st_finish : st_read_last;
                    end else begin
                        state_next = store_op ? st_write : st_read;
                    end
                end
            end
            st_read: begin
                if (abort) begin
                    state_next = st_idle;
                end else begin
                    issue = 1'b1;
                    if (last) state_next = st_read_last;
                end
            end
            st_write: begin
                issue = 1'b1;
                if (last) state_next = st_finish;
            end
            st_read_last: state_next = abort ? st_idle : st_finish;
            st_finish: begin
                state_next = st_idle;
                if (!abort) begin
                    pop         = 1'b1;
                    finish_load = !store_op;
                end
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk_in) begin
        mem_req.write <= store_op;
        mem_req.addr  <= addr;
        mem_req.wdata <= wdata_byte;
        result.tag    <= head.tag;
        result.value  <= result_value; // includes the byte arriving now
        if (rst_in) begin
            state         <= st_idle;
            mem_req.valid <= 1'b0;
            result.valid  <= 1'b0;
            capture       <= 1'b0;
        end else begin
            state         <= state_next;
            mem_req.valid <= issue;
            result.valid  <= finish_load;
            capture       <= mem_req.valid && !mem_req.write; // read data due now
        end
    end

    // a request out of st_idle only for a head that may go
    a_idle_start_ready: assert property (
        @(posedge clk_in) disable iff (rst_in)
        (state == st_idle && issue) |->
            (head.rs1_dep == '0 && head.rs2_dep == '0 && (!store_op || head.committed))
    ) else $error("mem_access_fsm: request issued in idle for a head that is not ready");

endmodule

`default_nettype wire

// ==== src/lsb_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsb_queue import lsb_op_pkg::*; #(
    parameter int DEPTH = 16
) (
    input  logic          clk_in,
    input  logic          rst_in,
    input  dispatch_t     dispatch,
    input  commit_bcast_t commit,
    input  logic          store_commit,
    input  logic          clear,
    input  logic          pop,
    output lsb_entry_t    head,
    output logic          head_go,
    output logic          abort,
    output logic          full
);

    localparam int PTR_W       = $clog2(DEPTH);
    localparam int CNT_W       = PTR_W + 1;
    localparam int FULL_MARGIN = 2;

    lsb_entry_t       slots [DEPTH];
    lsb_entry_t       entry_in;
    logic [PTR_W-1:0] head_ptr;
    logic [PTR_W-1:0] tail_ptr;
    logic [PTR_W-1:0] commit_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] commit_cnt; // committed entries form a prefix from head
    logic             dispatch_ok;
    logic             commit_ok;
    logic             pop_committed;
    logic             head_ready;

    // replace a waiting operand with the broadcast value
    function automatic lsb_entry_t wake(lsb_entry_t e, commit_bcast_t c);
        lsb_entry_t w;
        w = e;
        if (c.valid && e.rs1_dep != '0 && e.rs1_dep == c.tag) begin
            w.rs1_dep = '0;
            w.rs1_val = c.value;
        end
        if (c.valid && e.rs2_dep != '0 && e.rs2_dep == c.tag) begin
            w.rs2_dep = '0;
            w.rs2_val = c.value;
        end
        return w;
    endfunction

    assign tail_ptr   = head_ptr + count[PTR_W-1:0];
    assign commit_ptr = head_ptr + commit_cnt[PTR_W-1:0];
    assign head       = slots[head_ptr];

    assign dispatch_ok   = dispatch.valid && !clear;
    assign commit_ok     = store_commit && !clear && (commit_cnt != count);
    assign pop_committed = pop && head.committed;

    assign head_ready = (head.rs1_dep == '0) && (head.rs2_dep == '0);
    assign head_go    = (count != '0) && head_ready && !clear &&
                        (!is_store(head.op) || head.committed);
    assign abort      = clear && (count != '0) && !head.committed;
    assign full       = count >= CNT_W'(DEPTH - FULL_MARGIN);

    // broadcast in the dispatch cycle is caught here
    always_comb begin
        entry_in = wake(lsb_entry_t'{
            op:        dispatch.op,
            tag:       dispatch.tag,
            imm:       dispatch.imm,
            rs1_dep:   dispatch.rs1_dep,
            rs1_val:   dispatch.rs1_val,
            rs2_dep:   dispatch.rs2_dep,
            rs2_val:   dispatch.rs2_val,
            committed: 1'b0
        }, commit);
    end

    always_ff @(posedge clk_in) begin
        for (int i = 0; i < DEPTH; i++) begin
            slots[i] <= wake(slots[i], commit);
        end
        if (commit_ok) begin
            slots[commit_ptr].committed <= 1'b1; // oldest unmarked
        end
        if (dispatch_ok) begin
            slots[tail_ptr] <= entry_in;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            head_ptr   <= '0;
            count      <= '0;
            commit_cnt <= '0;
        end else begin
            if (pop) begin
                head_ptr <= head_ptr + 1'b1;
            end
            if (clear) begin
                // only committed stores survive
                count      <= commit_cnt - CNT_W'(pop_committed);
                commit_cnt <= commit_cnt - CNT_W'(pop_committed);
            end else begin
                count      <= count + CNT_W'(dispatch_ok) - CNT_W'(pop);
                commit_cnt <= commit_cnt + CNT_W'(commit_ok) - CNT_W'(pop_committed);
            end
        end
    end

    a_no_dispatch_when_full: assert property (
        @(posedge clk_in) disable iff (rst_in) dispatch.valid |-> !full
    ) else $error("lsb_queue: dispatch while full");

    a_no_pop_when_empty: assert property (
        @(posedge clk_in) disable iff (rst_in) pop |-> count != '0
    ) else $error("lsb_queue: pop while empty");

endmodule

`default_nettype wire

// ==== src/byte_lane_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module byte_lane_unit import lsb_cfg_pkg::*, lsb_op_pkg::*; (
    input  logic       clk_in,
    input  logic       rst_in,
    input  logic       capture,
    input  mem_op_e    op,
    input  word_t      store_data,
    input  logic [1:0] byte_index,
    input  byte_t      mem_byte,
    output byte_t      wdata_byte,
    output word_t      result_value
);

    word_t      gathered;
    word_t      merged;
    logic [1:0] idx_d1;
    logic [1:0] idx_d2; // lane of the byte requested two cycles back

    assign wdata_byte = store_data[{byte_index, 3'b000} +: 8];

    always_comb begin
        merged = gathered;
        if (capture) begin
            merged[{idx_d2, 3'b000} +: 8] = mem_byte;
        end
    end

    always_comb begin
        case (op)
            op_lb:   result_value = {{(WORD_W-8){merged[7]}}, merged[7:0]};
            op_lh:   result_value = {{(WORD_W-16){merged[15]}}, merged[15:0]};
            op_lbu:  result_value = {{(WORD_W-8){1'b0}}, merged[7:0]};
            op_lhu:  result_value = {{(WORD_W-16){1'b0}}, merged[15:0]};
            default: result_value = merged; // lw
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (capture) begin
            gathered <= merged;
        end
        if (rst_in) begin
            idx_d1 <= 2'd0;
            idx_d2 <= 2'd0;
        end else begin
            idx_d1 <= byte_index;
            idx_d2 <= idx_d1;
        end
    end

endmodule

`default_nettype wire

// ==== src/byte_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module byte_counter import lsb_cfg_pkg::*, lsb_op_pkg::*; (
    input  logic       clk_in,
    input  logic       rst_in,
    input  logic       start,
    input  logic       step,
    input  mem_op_e    op,
    input  addr_t      base_addr,
    output addr_t      addr,
    output logic [2:0] remaining,
    output logic [1:0] byte_index
);

    addr_t      addr_q;
    logic [2:0] rem_q;
    logic [2:0] op_bytes;
    logic [1:0] idx_q;

    always_comb begin
        case (op)
            op_lw, op_sw:         op_bytes = 3'd4;
            op_lh, op_lhu, op_sh: op_bytes = 3'd2;
            default:              op_bytes = 3'd1;
        endcase
    end

    // start shows the fresh values in the same cycle
    assign addr       = start ? base_addr : addr_q;
    assign remaining  = start ? op_bytes : rem_q;
    assign byte_index = start ? 2'd0 : idx_q;

    always_ff @(posedge clk_in) begin
        if (step) begin
            addr_q <= addr + addr_t'(1);
        end else if (start) begin
            addr_q <= addr;
        end
        if (rst_in) begin
            rem_q <= 3'd0;
            idx_q <= 2'd0;
        end else if (step) begin
            rem_q <= remaining - 3'd1;
            idx_q <= byte_index + 2'd1;
        end else if (start) begin
            rem_q <= remaining;
            idx_q <= byte_index;
        end
    end

    a_no_step_at_zero: assert property (
        @(posedge clk_in) disable iff (rst_in) step |-> remaining != 3'd0
    ) else $error("byte_counter: step with no bytes left");

endmodule

`default_nettype wire

// ==== src/lsb_op_pkg.sv ====
`default_nettype none

package lsb_op_pkg;

    import lsb_cfg_pkg::*;

    typedef enum logic [3:0] {
        op_lb,
        op_lh,
        op_lw,
        op_lbu,
        op_lhu,
        op_sb,
        op_sh,
        op_sw
    } mem_op_e;

    typedef enum logic [2:0] {
        st_idle,
        st_read,
        st_read_last, // last read issued, waiting on its byte
        st_write,
        st_finish
    } access_state_e;

    typedef struct packed {
        logic    valid;
        mem_op_e op;
        tag_t    tag;
        word_t   imm;
        tag_t    rs1_dep;
        word_t   rs1_val;
        tag_t    rs2_dep;
        word_t   rs2_val;
    } dispatch_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t value;
    } commit_bcast_t;

    typedef struct packed {
        mem_op_e op;
        tag_t    tag;
        word_t   imm;
        tag_t    rs1_dep;
        word_t   rs1_val;
        tag_t    rs2_dep;
        word_t   rs2_val;
        logic    committed;
    } lsb_entry_t;

    typedef struct packed {
        logic  valid;
        logic  write; // 1 for a store byte
        addr_t addr;
        byte_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t value;
    } load_result_t;

    function automatic logic is_store(mem_op_e op);
        return op inside {op_sb, op_sh, op_sw};
    endfunction

endpackage

`default_nettype wire

// ==== src/lsb_cfg_pkg.sv ====
`default_nettype none

package lsb_cfg_pkg;

    localparam int WORD_W = 32; // operand and result width
    localparam int TAG_W  = 5;  // rob tag, zero means no dependency
    localparam int ADDR_W = 17;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [7:0]        byte_t;

endpackage

`default_nettype wire
